/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= ads816x_ctrl.f
TOP       ?= tb_ads816x_ctrl
RTL_TOP   ?= ads816x_ctrl
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* ads816x_ctrl.f */
hdl/adc_cmd_pkg.sv
hdl/adc_spi_pkg.sv
hdl/spi_frame_if.sv
hdl/cmd_sequencer.sv
hdl/spi_frame_engine.sv
hdl/sample_packer.sv
hdl/ads816x_ctrl.sv
sim/tb_clock.sv
sim/adc_model.sv
sim/tb_ads816x_ctrl.sv

/* hdl/adc_cmd_pkg.sv */
`default_nettype none

package adc_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Command word layout
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] cmd_word_t;       // One entry of the command buffer

  localparam int OPCODE_LSB = 29;        // Opcode sits in bits 31:29
  localparam int OPCODE_W   = 3;

  // Command opcodes, anything else is rejected
  typedef enum logic [OPCODE_W-1:0] {
    CMD_NO_OP   = 3'd0,                  // Wait cycles or triggers
    CMD_SET_ORD = 3'd1,                  // Load channel sample order
    CMD_ADC_RD  = 3'd2                   // Read all eight channels
  } opcode_t;

  localparam int TRIG_BIT = 28;          // Count triggers instead of cycles
  localparam int CONT_BIT = 27;          // Next command must already be queued
  localparam int COUNT_W  = 25;          // Delay or trigger count in bits 24:0

  //////////////////////////////////////////////////////////////////////
  // Channel order
  //////////////////////////////////////////////////////////////////////

  typedef logic [2:0] channel_t;

  localparam int NUM_CH        = 8;
  localparam int ORDER_FIELD_W = 3;      // Entry i of SET_ORD at bits 3i+2:3i

  // Sequencer states
  typedef enum logic [2:0] {
    S_RESET,
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_ADC_RD,
    S_ERROR                              // Terminal, left only through reset
  } seq_state_t;

endpackage

`default_nettype wire

/* hdl/adc_spi_pkg.sv */
`default_nettype none

package adc_spi_pkg;

  typedef logic [15:0] sample_t;         // One 16-bit reply from the ADC

  localparam int FRAME_BITS = 16;        // Clocks with n_cs low per frame

  // On-the-fly request is 10, channel, then zero padding
  localparam logic [1:0] OTF_REQ_PREFIX = 2'b10;
  localparam int OTF_CH_W  = 3;
  localparam int OTF_PAD_W = FRAME_BITS - $bits(OTF_REQ_PREFIX) - OTF_CH_W;

  localparam int FRAMES_PER_READ = 9;    // Eight requests plus one to flush the last reply

  localparam logic [7:0] DEFAULT_CS_HIGH = 8'd8;  // Used until the input is latched

  // Frame engine states
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_CS_HIGH,                         // n_cs held high before the frame
    ENG_SHIFT                            // n_cs low, bits moving
  } eng_state_t;

endpackage

`default_nettype wire

/* hdl/ads816x_ctrl.sv */
`default_nettype none

module ads816x_ctrl (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [7:0]             n_cs_high_time,

  // Command buffer
  output logic                   cmd_buf_rd_en,
  input  adc_cmd_pkg::cmd_word_t cmd_buf_word,
  input  logic                   cmd_buf_empty,

  // Data buffer
  output logic                   data_buf_wr_en,
  output logic [31:0]            data_word,
  input  logic                   data_buf_full,

  input  logic                   trigger,
  output logic                   waiting_for_trig,

  // Sticky error flags
  output logic                   bad_cmd,
  output logic                   cmd_buf_underflow,
  output logic                   data_buf_overflow,
  output logic                   unexp_trig,
  output logic                   delay_too_short,

  // ADC SPI
  output logic                   n_cs,
  output logic                   mosi,
  input  logic                   miso
);

  logic in_error;      // Stops the engine and clears the pair phase

  spi_frame_if frame ();

  cmd_sequencer i_seq (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_buf_rd_en     (cmd_buf_rd_en),
    .cmd_buf_word      (cmd_buf_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .trigger           (trigger),
    .overflow          (data_buf_overflow),
    .waiting_for_trig  (waiting_for_trig),
    .bad_cmd           (bad_cmd),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig),
    .delay_too_short   (delay_too_short),
    .in_error          (in_error),
    .frame             (frame.seq)
  );

  spi_frame_engine i_eng (
    .clk            (clk),
    .resetn         (resetn),
    .n_cs_high_time (n_cs_high_time),
    .abort          (in_error),
    .n_cs           (n_cs),
    .mosi           (mosi),
    .miso           (miso),
    .frame          (frame.eng)
  );

  sample_packer i_pack (
    .clk               (clk),
    .resetn            (resetn),
    .abort             (in_error),
    .data_buf_wr_en    (data_buf_wr_en),
    .data_word         (data_word),
    .data_buf_full     (data_buf_full),
    .data_buf_overflow (data_buf_overflow),
    .frame             (frame.sink)
  );

endmodule

`default_nettype wire

/* hdl/cmd_sequencer.sv */
`default_nettype none

module cmd_sequencer (
  input  logic                  clk,
  input  logic                  resetn,
  output logic                  cmd_buf_rd_en,
  input  adc_cmd_pkg::cmd_word_t cmd_buf_word,
  input  logic                  cmd_buf_empty,
  input  logic                  trigger,
  input  logic                  overflow,          // From the packer
  output logic                  waiting_for_trig,
  output logic                  bad_cmd,
  output logic                  cmd_buf_underflow,
  output logic                  unexp_trig,
  output logic                  delay_too_short,
  output logic                  in_error,
  spi_frame_if.seq              frame
);
  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  localparam int FIDX_W = $clog2(FRAMES_PER_READ);
  localparam logic [FIDX_W-1:0] LAST_FRAME = FIDX_W'(FRAMES_PER_READ - 1);

  seq_state_t             state, next_cmd_state;
  opcode_t                op;
  logic                   op_valid;
  logic [COUNT_W-1:0]     delay_cnt, trig_cnt;
  logic                   wait_trig;             // Current command counts triggers
  logic                   expect_next;           // Continue bit of current command
  channel_t               sample_order [NUM_CH];
  logic [FIDX_W-1:0]      frame_idx, next_idx;
  logic                   frames_done;           // Ninth frame finished
  logic                   last_done;
  logic                   delay_done, trig_done, cmd_done;
  logic                   trig_ok;
  logic                   unexp_now, short_now, under_now, bad_now, fault;

  //////////////////////////////////////////////////////////////////////
  // Decode and completion
  //////////////////////////////////////////////////////////////////////

  assign op       = opcode_t'(cmd_buf_word[OPCODE_LSB +: OPCODE_W]);
  assign op_valid = op inside {CMD_NO_OP, CMD_SET_ORD, CMD_ADC_RD};

  always_comb begin
    case (op)
      CMD_NO_OP:   next_cmd_state = cmd_buf_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
      CMD_SET_ORD: next_cmd_state = S_IDLE;   // Order loads on the pop itself
      CMD_ADC_RD:  next_cmd_state = S_ADC_RD;
      default:     next_cmd_state = S_ERROR;  // Unknown opcode
    endcase
  end

  assign delay_done = (delay_cnt == '0);
  assign trig_done  = (trig_cnt == '0) || (trigger && trig_cnt == COUNT_W'(1));
  assign last_done  = frame.done && (frame_idx == LAST_FRAME);

  always_comb begin
    case (state)
      S_IDLE:      cmd_done = 1'b1;             // Ready for a new word any time
      S_DELAY:     cmd_done = delay_done;
      S_TRIG_WAIT: cmd_done = trig_done;
      S_ADC_RD:    cmd_done = frames_done && (wait_trig ? trig_done : delay_done);
      default:     cmd_done = 1'b0;
    endcase
  end

  // Errors
  assign trig_ok   = (state == S_TRIG_WAIT) || (state == S_ADC_RD && wait_trig);
  assign unexp_now = trigger && !trig_ok;
  assign short_now = (state == S_ADC_RD) && !wait_trig && !frames_done && !last_done
                     && delay_done;             // Timer ran out mid read
  assign under_now = cmd_done && expect_next && cmd_buf_empty;
  assign fault     = unexp_now || short_now || under_now || overflow;

  assign cmd_buf_rd_en    = cmd_done && !cmd_buf_empty && !fault;
  assign bad_now          = cmd_buf_rd_en && !op_valid;
  assign waiting_for_trig = (state == S_TRIG_WAIT) || (state == S_ADC_RD && wait_trig && frames_done);
  assign in_error         = (state == S_ERROR);

  //////////////////////////////////////////////////////////////////////
  // State machine and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_RESET;
    end else if (fault) begin
      state <= S_ERROR;
    end else begin
      case (state)
        S_RESET: state <= S_IDLE;
        S_ERROR: state <= S_ERROR;                    // Stuck until reset
        default: begin
          if (cmd_done) begin
            if (!cmd_buf_empty) state <= next_cmd_state;
            else                state <= S_IDLE;      // Underflow already caught by fault
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_cnt   <= '0;
      trig_cnt    <= '0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (cmd_buf_rd_en) begin
      expect_next <= cmd_buf_word[CONT_BIT];
      wait_trig   <= 1'b0;
      if (op == CMD_NO_OP || op == CMD_ADC_RD) begin
        wait_trig <= cmd_buf_word[TRIG_BIT];
        if (cmd_buf_word[TRIG_BIT]) trig_cnt  <= cmd_buf_word[COUNT_W-1:0];
        else                        delay_cnt <= cmd_buf_word[COUNT_W-1:0];
      end
    end else begin
      if (!delay_done)              delay_cnt <= delay_cnt - 1'b1;  // Free running from pop
      if (trigger && trig_cnt != '0) trig_cnt <= trig_cnt - 1'b1;
    end
  end

  // Sample order, identity after reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CH; i++) sample_order[i] <= channel_t'(i);
    end else if (cmd_buf_rd_en && op == CMD_SET_ORD) begin
      for (int i = 0; i < NUM_CH; i++)
        sample_order[i] <= cmd_buf_word[ORDER_FIELD_W*i +: ORDER_FIELD_W];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame requests
  //////////////////////////////////////////////////////////////////////

  assign next_idx = frame_idx + 1'b1;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_idx     <= '0;
      frames_done   <= 1'b0;
      frame.start   <= 1'b0;
      frame.channel <= '0;
      frame.capture <= 1'b0;
    end else begin
      frame.start <= 1'b0;                               // Single cycle pulse
      if (cmd_buf_rd_en && op == CMD_ADC_RD) begin
        frame_idx     <= '0;
        frames_done   <= 1'b0;
        frame.start   <= 1'b1;
        frame.channel <= sample_order[0];
        frame.capture <= 1'b0;                           // First reply is stale
      end else if (state == S_ADC_RD && frame.done && !fault) begin
        if (last_done) begin
          frames_done <= 1'b1;
        end else begin
          frame_idx     <= next_idx;
          frame.start   <= 1'b1;
          frame.capture <= 1'b1;
          // Flush frame asks for channel 0
          frame.channel <= (next_idx < NUM_CH) ? sample_order[next_idx[2:0]] : '0;
        end
      end
    end
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bad_cmd           <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      unexp_trig        <= 1'b0;
      delay_too_short   <= 1'b0;
    end else begin
      if (bad_now)   bad_cmd           <= 1'b1;
      if (under_now) cmd_buf_underflow <= 1'b1;
      if (unexp_now) unexp_trig        <= 1'b1;
      if (short_now) delay_too_short   <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/sample_packer.sv */
`default_nettype none

module sample_packer (
  input  logic        clk,
  input  logic        resetn,
  input  logic        abort,
  output logic        data_buf_wr_en,
  output logic [31:0] data_word,
  input  logic        data_buf_full,
  output logic        data_buf_overflow,
  spi_frame_if.sink   frame
);
  import adc_spi_pkg::*;

  logic    second;       // Next reply completes a pair
  logic    word_ready;   // data_word holds a fresh pair
  sample_t first_q;      // First reply of the pair

  //////////////////////////////////////////////////////////////////////
  // Pair phase and write strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      second            <= 1'b0;
      word_ready        <= 1'b0;
      data_buf_overflow <= 1'b0;
    end else begin
      word_ready <= frame.rx_valid && second && !abort;
      if (abort)               second <= 1'b0;
      else if (frame.rx_valid) second <= !second;
      if (word_ready && data_buf_full) data_buf_overflow <= 1'b1;  // Word is dropped
    end
  end

  // No write while the buffer is full
  assign data_buf_wr_en = word_ready && !data_buf_full;

  // Later reply goes to the upper half
  always_ff @(posedge clk) begin
    if (frame.rx_valid) begin
      if (!second) first_q   <= frame.rx_data;
      else         data_word <= {frame.rx_data, first_q};
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_frame_engine.sv */
`default_nettype none

module spi_frame_engine (
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] n_cs_high_time,
  input  logic       abort,            // Sequencer in error
  output logic       n_cs,
  output logic       mosi,
  input  logic       miso,
  spi_frame_if.eng   frame
);
  import adc_spi_pkg::*;

  localparam int BIT_W = $clog2(FRAME_BITS);

  eng_state_t       state;
  logic [7:0]       cs_high_q;         // Latched high time
  logic             cs_latched;
  logic [7:0]       cs_timer;
  logic [BIT_W-1:0] bit_cnt;           // Bits left in the frame
  logic             capture_q;
  sample_t          tx_sr, rx_sr;

  assign mosi = tx_sr[FRAME_BITS-1];   // MSB first

  // High time is sampled once, right after reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cs_high_q  <= DEFAULT_CS_HIGH;
      cs_latched <= 1'b0;
    end else if (!cs_latched) begin
      cs_high_q  <= n_cs_high_time;
      cs_latched <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || abort) begin
      state          <= ENG_IDLE;
      n_cs           <= 1'b1;
      cs_timer       <= '0;
      bit_cnt        <= '0;
      frame.done     <= 1'b0;
      frame.rx_valid <= 1'b0;
    end else begin
      frame.done     <= 1'b0;
      frame.rx_valid <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (frame.start) begin
            state     <= ENG_CS_HIGH;
            cs_timer  <= cs_high_q;
            capture_q <= frame.capture;
          end
        end
        ENG_CS_HIGH: begin
          if (cs_timer <= 8'd1) begin                 // Zero behaves like one
            state   <= ENG_SHIFT;
            n_cs    <= 1'b0;
            bit_cnt <= BIT_W'(FRAME_BITS - 1);
          end else begin
            cs_timer <= cs_timer - 1'b1;
          end
        end
        ENG_SHIFT: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin                    // Last bit this cycle
            state          <= ENG_IDLE;
            n_cs           <= 1'b1;
            frame.done     <= 1'b1;
            frame.rx_valid <= capture_q;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shift registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_sr <= '0;                                    // Keeps mosi low when idle
    end else if (state == ENG_IDLE && frame.start) begin
      tx_sr <= {OTF_REQ_PREFIX, frame.channel, {OTF_PAD_W{1'b0}}};
    end else if (state == ENG_SHIFT) begin
      tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (state == ENG_SHIFT) begin
      rx_sr <= {rx_sr[FRAME_BITS-2:0], miso};         // Sampled in the clk domain
      if (bit_cnt == '0) frame.rx_data <= {rx_sr[FRAME_BITS-2:0], miso};
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_frame_if.sv */
`default_nettype none

// Frame request and reply path between sequencer, engine and packer
interface spi_frame_if;
  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  logic     start;     // One-cycle request, taken only when the engine is idle
  channel_t channel;   // Channel to request in this frame
  logic     capture;   // Reply of this frame belongs to an earlier request
  logic     done;      // Frame finished, n_cs just went high
  logic     rx_valid;  // rx_data carries a sample
  sample_t  rx_data;

  modport seq (
    output start, channel, capture,
    input  done
  );

  modport eng (
    input  start, channel, capture,
    output done, rx_valid, rx_data
  );

  modport sink (
    input rx_valid, rx_data
  );

endinterface

`default_nettype wire

/* sim/adc_model.sv */
`default_nettype none

// ADC answering each frame with the channel asked for in the frame before
module adc_model (
  input  logic clk,
  input  logic n_cs,
  input  logic mosi,
  output logic miso
);
  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  integer      seed;
  logic [12:0] sample_val [NUM_CH];      // One fixed conversion result per channel
  channel_t    prev_ch;                  // Request of the last complete frame
  sample_t     req;                      // Request bits collected from mosi
  sample_t     reply;
  int          cnt;                      // Bits moved in this frame
  int          bad_reqs;                 // Complete frames not shaped as 10, channel, zeros

  initial begin
    seed = 32'he811b050;
    for (int i = 0; i < NUM_CH; i++) sample_val[i] = 13'($random(seed));
    prev_ch  = '0;
    req      = '0;
    reply    = '0;
    cnt      = 0;
    bad_reqs = 0;
    miso     = 1'b0;
  end

  // Falling edge keeps miso stable around the rising edge where it is sampled
  always @(negedge clk) begin
    if (n_cs) begin
      if (cnt == FRAME_BITS) begin
        prev_ch = channel_t'(req[13:11]);                       // Channel follows prefix 10
        if (req[15:14] != 2'b10 || req[10:0] != '0) bad_reqs++;
      end
      cnt = 0;                                                  // Also drops aborted frames
      miso <= 1'b0;
    end else begin
      if (cnt == 0) reply = {prev_ch, sample_val[prev_ch]};
      req = {req[FRAME_BITS-2:0], mosi};
      if (cnt < FRAME_BITS) miso <= reply[FRAME_BITS-1-cnt];    // MSB first
      cnt++;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_ads816x_ctrl.sv */
`default_nettype none

module tb_ads816x_ctrl;
  import adc_cmd_pkg::*;
  import adc_spi_pkg::*;

  localparam int NT = 8, MAXC = 3, H = 8, SETTLE = 40;

  logic clk, por_n, test_rst_n, resetn;
  logic [7:0] n_cs_high_time;
  logic cmd_buf_rd_en, cmd_buf_empty, data_buf_wr_en, data_buf_full, trigger;
  logic waiting_for_trig, n_cs, mosi, miso;
  logic bad_cmd, cmd_buf_underflow, data_buf_overflow, unexp_trig, delay_too_short;
  cmd_word_t cmd_buf_word;
  logic [31:0] data_word;
  logic [4:0] flags;

  cmd_word_t   cmd_q[$];                 // Command buffer
  logic [31:0] data_q[$];                // Data buffer
  int errors, passed, pops, cycles, limit;
  logic pop_now;

  // Test table
  string       tab_name [NT];
  cmd_word_t   tab_cmd [NT][MAXC];
  int          tab_ncmd [NT], tab_ntrig [NT], tab_pops [NT], tab_words [NT];
  logic        tab_trig_wait [NT], tab_full [NT];
  logic [23:0] tab_order [NT];           // Sample order the words must follow
  logic [4:0]  tab_flags [NT];           // bad, underflow, overflow, unexp, short
  string       flag_name [5] = '{"delay_too_short", "unexp_trig", "data_buf_overflow",
                                 "cmd_buf_underflow", "bad_cmd"};

  assign resetn = por_n & test_rst_n;
  assign flags  = {bad_cmd, cmd_buf_underflow, data_buf_overflow, unexp_trig, delay_too_short};

  tb_clock #(.PERIOD(40), .RESET_CYCLES(3)) i_clk (.clk(clk), .resetn(por_n));
  adc_model i_adc (.clk(clk), .n_cs(n_cs), .mosi(mosi), .miso(miso));

  ads816x_ctrl i_dut (
    .clk(clk), .resetn(resetn), .n_cs_high_time(n_cs_high_time),
    .cmd_buf_rd_en(cmd_buf_rd_en), .cmd_buf_word(cmd_buf_word), .cmd_buf_empty(cmd_buf_empty),
    .data_buf_wr_en(data_buf_wr_en), .data_word(data_word), .data_buf_full(data_buf_full),
    .trigger(trigger), .waiting_for_trig(waiting_for_trig),
    .bad_cmd(bad_cmd), .cmd_buf_underflow(cmd_buf_underflow),
    .data_buf_overflow(data_buf_overflow), .unexp_trig(unexp_trig),
    .delay_too_short(delay_too_short), .n_cs(n_cs), .mosi(mosi), .miso(miso)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input sample_t exp_hi, input sample_t exp_lo);
    if (got !== {exp_hi, exp_lo}) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, {exp_hi, exp_lo});
    end
  endtask

  // Model reply for a channel with the channel number on top
  function automatic sample_t model_sample(input channel_t ch);
    return {ch, i_adc.sample_val[ch]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Buffer models and cycle stepping
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cmd_buf();
    cmd_buf_empty = (cmd_q.size() == 0);
    cmd_buf_word  = cmd_buf_empty ? '0 : cmd_q[0];   // Word shown before the pop
  endtask

  task automatic step(input logic trig);
    @(negedge clk);                                   // Outputs settled here
    pop_now = cmd_buf_rd_en;
    if (data_buf_wr_en) begin
      if (data_buf_full) begin
        errors++;
        $display("ERROR t=%0t a data word was written while data_buf_full was high", $time);
      end
      data_q.push_back(data_word);
    end
    @(posedge clk);
    #5;
    if (pop_now) begin
      pops++;
      if (cmd_q.size() == 0) begin
        errors++;
        $display("ERROR t=%0t the DUT popped an empty command buffer", $time);
      end else begin
        void'(cmd_q.pop_front());
      end
    end
    trigger = trig;
    drive_cmd_buf();
  endtask

  task automatic set_test(input int t, input string name, input int ncmd,
                          input cmd_word_t c0, input cmd_word_t c1, input int ntrig,
                          input logic trig_wait, input logic full, input logic [23:0] order,
                          input logic [4:0] exp_flags, input int exp_pops, input int exp_words);
    tab_name[t]   = name;
    tab_ncmd[t]   = ncmd;
    tab_cmd[t][0] = c0;
    tab_cmd[t][1] = c1;
    tab_cmd[t][2] = '0;
    tab_ntrig[t]  = ntrig;
    tab_trig_wait[t] = trig_wait;
    tab_full[t]   = full;
    tab_order[t]  = order;
    tab_flags[t]  = exp_flags;
    tab_pops[t]   = exp_pops;
    tab_words[t]  = exp_words;
  endtask

  task automatic run_test(input int t);
    int   errs0, trig_left, k;
    logic trig, done;
    channel_t ch_lo, ch_hi;
    errs0 = errors;
    cmd_q.delete();
    data_q.delete();
    data_buf_full = tab_full[t];
    test_rst_n    = 1'b0;
    repeat (3) step(1'b0);
    test_rst_n = 1'b1;
    pops       = 0;
    // Idle after reset with an empty buffer
    repeat (4) begin
      step(1'b0);
      check_flag("n_cs", n_cs, 1'b1);
      check_flag("cmd_buf_rd_en", cmd_buf_rd_en, 1'b0);
      check_flag("data_buf_wr_en", data_buf_wr_en, 1'b0);
      check_flag("waiting_for_trig", waiting_for_trig, 1'b0);
      for (int f = 0; f < 5; f++) check_flag(flag_name[f], flags[f], 1'b0);
    end
    check_count("pops while empty", pops, 0);
    for (int i = 0; i < tab_ncmd[t]; i++) cmd_q.push_back(tab_cmd[t][i]);
    drive_cmd_buf();
    trig_left = tab_ntrig[t];
    k         = 0;
    done      = 1'b0;
    while (!done) begin
      trig = 1'b0;
      k++;
      if (trig_left > 0 && k >= 8 && k % 4 == 0) begin   // Spaced triggers
        if (tab_trig_wait[t]) begin
          check_flag("waiting_for_trig", waiting_for_trig, 1'b1);
          check_count("pops before last trigger", pops, 1);
        end
        trig = 1'b1;
        trig_left--;
      end
      step(trig);
      done = (trig_left == 0) && (pops >= tab_pops[t]) && (data_q.size() >= tab_words[t])
             && ((flags & tab_flags[t]) == tab_flags[t]);
    end
    // Quiet window where nothing more may happen
    repeat (SETTLE) begin
      step(1'b0);
      if (tab_flags[t] != '0) check_flag("n_cs", n_cs, 1'b1);
    end
    check_count("cmd pops", pops, tab_pops[t]);
    check_count("data words", data_q.size(), tab_words[t]);
    check_flag("waiting_for_trig", waiting_for_trig, 1'b0);
    for (int f = 0; f < 5; f++) check_flag(flag_name[f], flags[f], tab_flags[t][f]);
    for (int w = 0; w < tab_words[t] && w < data_q.size(); w++) begin
      ch_lo = tab_order[t][ORDER_FIELD_W*(2*w) +: ORDER_FIELD_W];
      ch_hi = tab_order[t][ORDER_FIELD_W*(2*w+1) +: ORDER_FIELD_W];
      check_word("data_word", data_q[w], model_sample(ch_hi), model_sample(ch_lo));
    end
    // Request shape on mosi and the channel of the flush frame
    check_count("malformed SPI requests", i_adc.bad_reqs, 0);
    if (tab_words[t] != 0) check_count("flush request channel", int'(i_adc.prev_ch), 0);
    if (errors == errs0) begin
      passed++;
      $display("test %0d %s: passed", t, tab_name[t]);
    end else begin
      $display("test %0d %s: FAILED", t, tab_name[t]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    cycles = 0;
    @(posedge clk);                                 // Limit is set up by now
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a test never finished", cycles);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    n_cs_high_time = 8'(H);
    test_rst_n     = 1'b0;
    trigger        = 1'b0;
    data_buf_full  = 1'b0;
    cmd_buf_word   = '0;
    cmd_buf_empty  = 1'b1;
    errors = 0;
    passed = 0;
    pops   = 0;
    set_test(0, "default order", 1, 32'h4000_0190, '0, 0, 0, 0, 24'o76543210, 5'b0, 1, 4);
    set_test(1, "sample order", 2, {3'd1, 5'd0, 24'o45270163}, 32'h4000_0190, 0, 0, 0,
             24'o45270163, 5'b0, 2, 4);
    set_test(2, "trigger wait", 2, 32'h1000_0003, 32'h0000_0005, 3, 1, 0, 24'o76543210,
             5'b0, 2, 0);
    set_test(3, "unexpected trigger", 0, '0, '0, 1, 0, 0, 24'o76543210, 5'b00010, 0, 0);
    set_test(4, "bad opcode", 2, 32'hA000_0000, 32'h0000_0005, 0, 0, 0, 24'o76543210,
             5'b10000, 1, 0);
    set_test(5, "underflow", 1, 32'h0800_0003, '0, 0, 0, 0, 24'o76543210, 5'b01000, 1, 0);
    set_test(6, "delay too short", 2, 32'h4000_000A, 32'h0000_0005, 0, 0, 0, 24'o76543210,
             5'b00001, 1, 0);
    set_test(7, "overflow", 2, 32'h4000_0190, 32'h0000_0005, 0, 0, 1, 24'o76543210,
             5'b00100, 1, 0);
    // Twice the frames, counts, reset and quiet window of all tests
    limit = 0;
    for (int t = 0; t < NT; t++) begin
      limit += FRAMES_PER_READ * (H + 17) + 3 + 4 + SETTLE + 8 + 4 * tab_ntrig[t];
      for (int i = 0; i < tab_ncmd[t]; i++) limit += int'(tab_cmd[t][i][COUNT_W-1:0]);
    end
    limit *= 2;
    for (int t = 0; t < NT; t++) run_test(t);
    $display("%0d tests, %0d passed, %0d failed, %0d errors", NT, passed, NT - passed, errors);
    if (errors == 0 && passed == NT) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

// Free running clock plus power-on reset
module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5 resetn = 1'b1;                    // Release just after the edge
  end

endmodule

`default_nettype wire
